//--- src/rv32i_pkg.sv
/*
 * rv32i base integer isa definitions
 * field widths and positions, opcodes and funct3 codes used by decode
 */
`default_nettype none

package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPC_W      = 7;
    localparam int F3_W       = 3;
    localparam int F7_W       = 7;
    localparam int SHAMT_W    = 5;
    localparam int IMM_I_W    = 12;
    localparam int IMM_U_W    = 20;

    // bit positions inside the instruction word
    localparam int OPC_LSB   = 0;
    localparam int RD_LSB    = 7;
    localparam int F3_LSB    = 12;
    localparam int RS1_LSB   = 15;
    localparam int RS2_LSB   = 20;
    localparam int F7_LSB    = 25;
    localparam int IMM_I_LSB = 20;
    localparam int IMM_U_LSB = 12;
    localparam int ALT_BIT   = 30;      // sub / sra select
    localparam int SIGN_BIT  = 31;      // immediate sign

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPC_W-1:0]      opcode_t;
    typedef logic [F3_W-1:0]       funct3_t;
    typedef logic [F7_W-1:0]       funct7_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    localparam funct3_t F3_ADD  = 3'b000;   // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;   // srl and sra share it
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // the only funct7 patterns allowed on immediate shifts
    localparam funct7_t F7_ZERO = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    localparam word_t ZERO_WORD = {XLEN{1'b0}};

endpackage

`default_nettype wire

//--- src/id_pkg.sv
/*
 * decode to execute micro-operation types
 * alu operation and result class handed down the pipeline
 */
`default_nettype none

package id_pkg;

    // alu operation within a result class
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_SLT  = 4'd3,
        OP_SLTU = 4'd4,
        OP_XOR  = 4'd5,
        OP_OR   = 4'd6,
        OP_AND  = 4'd7,
        OP_SLL  = 4'd8,
        OP_SRL  = 4'd9,
        OP_SRA  = 4'd10,
        OP_LUI  = 4'd11
    } alu_op_e;

    // which execute result mux leg is taken
    typedef enum logic [2:0] {
        SEL_NONE    = 3'd0,
        SEL_LOGIC   = 3'd1,
        SEL_SHIFT   = 3'd2,     // lui rides on the shift leg
        SEL_ARITH   = 3'd3,
        SEL_COMPARE = 3'd4
    } alu_sel_e;

endpackage

`default_nettype wire

//--- src/decode_if.sv
/*
 * decoded control bundle
 * carries decoder results to the operand selects and the id/ex register
 */
`default_nettype none

interface decode_if;

    id_pkg::alu_op_e       aluop;
    id_pkg::alu_sel_e      alusel;
    rv32i_pkg::reg_addr_t  wd;          // destination register
    logic                  wreg;
    logic                  inst_valid;
    logic                  rs1_read;
    logic                  rs2_read;
    rv32i_pkg::reg_addr_t  rs1_addr;
    rv32i_pkg::reg_addr_t  rs2_addr;
    rv32i_pkg::word_t      imm1;        // used when rs1 is not read
    rv32i_pkg::word_t      imm2;        // used when rs2 is not read

    modport dec (
        output aluop, alusel, wd, wreg, inst_valid,
        output rs1_read, rs2_read, rs1_addr, rs2_addr, imm1, imm2
    );

    modport opnd (
        input rs1_read, rs2_read, rs1_addr, rs2_addr, imm1, imm2
    );

    modport pipe (
        input aluop, alusel, wd, wreg, inst_valid
    );

endinterface

`default_nettype wire

//--- src/inst_decoder.sv
/*
 * instruction decoder
 * maps lui, auipc and the alu instructions to control, read requests and immediates
 */
`default_nettype none

module inst_decoder (
    input  wire rv32i_pkg::inst_t inst_i,
    input  wire rv32i_pkg::word_t pc_i,
    decode_if.dec                 dec_o
);

    rv32i_pkg::opcode_t opcode;
    rv32i_pkg::funct3_t funct3;
    rv32i_pkg::funct7_t funct7;
    logic               alt;
    logic               reg_form;
    logic               is_shift;
    logic               shift_bad;
    logic               legal;
    rv32i_pkg::word_t   imm_i_sext;
    rv32i_pkg::word_t   imm_u;
    rv32i_pkg::word_t   shamt_zext;
    id_pkg::alu_op_e    f3_op;
    id_pkg::alu_sel_e   f3_sel;

    assign opcode = inst_i[rv32i_pkg::OPC_LSB +: rv32i_pkg::OPC_W];
    assign funct3 = inst_i[rv32i_pkg::F3_LSB +: rv32i_pkg::F3_W];
    assign funct7 = inst_i[rv32i_pkg::F7_LSB +: rv32i_pkg::F7_W];
    assign alt    = inst_i[rv32i_pkg::ALT_BIT];

    // register fields are passed on whatever the opcode
    assign dec_o.wd       = inst_i[rv32i_pkg::RD_LSB +: rv32i_pkg::REG_ADDR_W];
    assign dec_o.rs1_addr = inst_i[rv32i_pkg::RS1_LSB +: rv32i_pkg::REG_ADDR_W];
    assign dec_o.rs2_addr = inst_i[rv32i_pkg::RS2_LSB +: rv32i_pkg::REG_ADDR_W];

    assign imm_i_sext = {{(rv32i_pkg::XLEN - rv32i_pkg::IMM_I_W){inst_i[rv32i_pkg::SIGN_BIT]}},
                         inst_i[rv32i_pkg::IMM_I_LSB +: rv32i_pkg::IMM_I_W]};
    assign imm_u      = {inst_i[rv32i_pkg::IMM_U_LSB +: rv32i_pkg::IMM_U_W],
                         {(rv32i_pkg::XLEN - rv32i_pkg::IMM_U_W){1'b0}}};
    assign shamt_zext = {{(rv32i_pkg::XLEN - rv32i_pkg::SHAMT_W){1'b0}},
                         inst_i[rv32i_pkg::RS2_LSB +: rv32i_pkg::SHAMT_W]};

    assign reg_form = (opcode == rv32i_pkg::OPC_OP);
    assign is_shift = (funct3 == rv32i_pkg::F3_SLL) || (funct3 == rv32i_pkg::F3_SR);

    // slli needs funct7 zero, srli/srai allow only the alt bit
    assign shift_bad = ((funct3 == rv32i_pkg::F3_SLL) && (funct7 != rv32i_pkg::F7_ZERO)) ||
                       ((funct3 == rv32i_pkg::F3_SR) && (funct7 != rv32i_pkg::F7_ZERO) &&
                        (funct7 != rv32i_pkg::F7_ALT));

    // operation named by funct3, same table for both alu forms
    always_comb begin
        f3_op  = id_pkg::OP_NONE;
        f3_sel = id_pkg::SEL_NONE;
        case (funct3)
            rv32i_pkg::F3_ADD: begin
                f3_op  = (alt && reg_form) ? id_pkg::OP_SUB : id_pkg::OP_ADD;  // no subi
                f3_sel = id_pkg::SEL_ARITH;
            end
            rv32i_pkg::F3_SLL: begin
                f3_op  = id_pkg::OP_SLL;
                f3_sel = id_pkg::SEL_SHIFT;
            end
            rv32i_pkg::F3_SLT: begin
                f3_op  = id_pkg::OP_SLT;
                f3_sel = id_pkg::SEL_COMPARE;
            end
            rv32i_pkg::F3_SLTU: begin
                f3_op  = id_pkg::OP_SLTU;
                f3_sel = id_pkg::SEL_COMPARE;
            end
            rv32i_pkg::F3_XOR: begin
                f3_op  = id_pkg::OP_XOR;
                f3_sel = id_pkg::SEL_LOGIC;
            end
            rv32i_pkg::F3_SR: begin
                f3_op  = alt ? id_pkg::OP_SRA : id_pkg::OP_SRL;
                f3_sel = id_pkg::SEL_SHIFT;
            end
            rv32i_pkg::F3_OR: begin
                f3_op  = id_pkg::OP_OR;
                f3_sel = id_pkg::SEL_LOGIC;
            end
            rv32i_pkg::F3_AND: begin
                f3_op  = id_pkg::OP_AND;
                f3_sel = id_pkg::SEL_LOGIC;
            end
            default: begin
                f3_op  = id_pkg::OP_NONE;
                f3_sel = id_pkg::SEL_NONE;
            end
        endcase
    end

    always_comb begin
        dec_o.aluop    = id_pkg::OP_NONE;       // idle unless recognised
        dec_o.alusel   = id_pkg::SEL_NONE;
        dec_o.rs1_read = 1'b0;
        dec_o.rs2_read = 1'b0;
        dec_o.imm1     = rv32i_pkg::ZERO_WORD;
        dec_o.imm2     = rv32i_pkg::ZERO_WORD;
        legal          = 1'b0;
        case (opcode)
            rv32i_pkg::OPC_LUI: begin
                legal        = 1'b1;
                dec_o.aluop  = id_pkg::OP_LUI;
                dec_o.alusel = id_pkg::SEL_SHIFT;
                dec_o.imm2   = imm_u;
            end
            rv32i_pkg::OPC_AUIPC: begin
                legal        = 1'b1;
                dec_o.aluop  = id_pkg::OP_ADD;
                dec_o.alusel = id_pkg::SEL_ARITH;
                dec_o.imm1   = pc_i;                // pc + upper immediate
                dec_o.imm2   = imm_u;
            end
            rv32i_pkg::OPC_OP_IMM: begin
                if (!shift_bad) begin
                    legal          = 1'b1;
                    dec_o.aluop    = f3_op;
                    dec_o.alusel   = f3_sel;
                    dec_o.rs1_read = 1'b1;
                    dec_o.imm2     = is_shift ? shamt_zext : imm_i_sext;
                end
            end
            rv32i_pkg::OPC_OP: begin
                legal          = 1'b1;
                dec_o.aluop    = f3_op;
                dec_o.alusel   = f3_sel;
                dec_o.rs1_read = 1'b1;
                dec_o.rs2_read = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        dec_o.wreg       = legal;   // every kept instruction writes rd
        dec_o.inst_valid = legal;
    end

endmodule

`default_nettype wire

//--- src/operand_forward.sv
/*
 * source operand select with forwarding
 * execute result beats memory result beats register file data
 */
`default_nettype none

module operand_forward (
    input  wire                  read_i,
    input  wire rv32i_pkg::reg_addr_t addr_i,
    input  wire rv32i_pkg::word_t     imm_i,
    input  wire rv32i_pkg::word_t     reg_data_i,
    input  wire                  ex_wreg_i,
    input  wire rv32i_pkg::reg_addr_t ex_wd_i,
    input  wire rv32i_pkg::word_t     ex_wdata_i,
    input  wire                  mem_wreg_i,
    input  wire rv32i_pkg::reg_addr_t mem_wd_i,
    input  wire rv32i_pkg::word_t     mem_wdata_i,
    output rv32i_pkg::word_t          operand_o
);

    logic ex_hit;
    logic mem_hit;

    // x0 is not filtered out here
    assign ex_hit  = ex_wreg_i && (ex_wd_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;          // port unused, take the immediate
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;     // youngest result first
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

`default_nettype wire

//--- src/id_ex_reg.sv
/*
 * id/ex pipeline register
 * holds decoded control and both operands for one cycle
 */
`default_nettype none

module id_ex_reg (
    input  wire                   clk,
    input  wire                   reset_i,
    decode_if.pipe                ctl_i,
    input  wire rv32i_pkg::word_t reg1_i,
    input  wire rv32i_pkg::word_t reg2_i,
    output id_pkg::alu_op_e       aluop_o,
    output id_pkg::alu_sel_e      alusel_o,
    output rv32i_pkg::reg_addr_t  wd_o,
    output logic                  wreg_o,
    output logic                  inst_valid_o,
    output rv32i_pkg::word_t      reg1_o,
    output rv32i_pkg::word_t      reg2_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            aluop_o      <= id_pkg::OP_NONE;   // bubble into execute
            alusel_o     <= id_pkg::SEL_NONE;
            wd_o         <= '0;
            wreg_o       <= 1'b0;
            inst_valid_o <= 1'b0;
            reg1_o       <= rv32i_pkg::ZERO_WORD;
            reg2_o       <= rv32i_pkg::ZERO_WORD;
        end else begin
            aluop_o      <= ctl_i.aluop;
            alusel_o     <= ctl_i.alusel;
            wd_o         <= ctl_i.wd;
            wreg_o       <= ctl_i.wreg;
            inst_valid_o <= ctl_i.inst_valid;
            reg1_o       <= reg1_i;            // already forwarded
            reg2_o       <= reg2_i;
        end
    end

endmodule

`default_nettype wire

//--- src/id_stage.sv
/*
 * rv32i instruction decode stage
 * decoder, two forwarding operand selects and the id/ex register
 */
`default_nettype none

module id_stage (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire rv32i_pkg::word_t     pc_i,
    input  wire rv32i_pkg::inst_t     inst_i,

    // register file read data, same cycle as the request
    input  wire rv32i_pkg::word_t     reg1_data_i,
    input  wire rv32i_pkg::word_t     reg2_data_i,

    // results still in flight in execute and memory
    input  wire                       ex_wreg_i,
    input  wire rv32i_pkg::reg_addr_t ex_wd_i,
    input  wire rv32i_pkg::word_t     ex_wdata_i,
    input  wire                       mem_wreg_i,
    input  wire rv32i_pkg::reg_addr_t mem_wd_i,
    input  wire rv32i_pkg::word_t     mem_wdata_i,

    // register file read requests
    output logic                      reg1_read_o,
    output logic                      reg2_read_o,
    output rv32i_pkg::reg_addr_t      reg1_addr_o,
    output rv32i_pkg::reg_addr_t      reg2_addr_o,

    // to execute, one cycle after inst_i
    output id_pkg::alu_op_e           aluop_o,
    output id_pkg::alu_sel_e          alusel_o,
    output rv32i_pkg::reg_addr_t      wd_o,
    output logic                      wreg_o,
    output logic                      inst_valid_o,
    output rv32i_pkg::word_t          reg1_o,
    output rv32i_pkg::word_t          reg2_o
);

    decode_if dec_if ();

    rv32i_pkg::word_t reg1_fwd;
    rv32i_pkg::word_t reg2_fwd;

    assign reg1_read_o = dec_if.rs1_read;
    assign reg2_read_o = dec_if.rs2_read;
    assign reg1_addr_o = dec_if.rs1_addr;
    assign reg2_addr_o = dec_if.rs2_addr;

    inst_decoder decoder_i (
        .inst_i (inst_i),
        .pc_i   (pc_i),
        .dec_o  (dec_if)
    );

    operand_forward fwd1_i (
        .read_i      (dec_if.rs1_read),
        .addr_i      (dec_if.rs1_addr),
        .imm_i       (dec_if.imm1),
        .reg_data_i  (reg1_data_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1_fwd)
    );

    operand_forward fwd2_i (
        .read_i      (dec_if.rs2_read),
        .addr_i      (dec_if.rs2_addr),
        .imm_i       (dec_if.imm2),
        .reg_data_i  (reg2_data_i),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2_fwd)
    );

    id_ex_reg id_ex_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .ctl_i        (dec_if),
        .reg1_i       (reg1_fwd),
        .reg2_i       (reg2_fwd),
        .aluop_o      (aluop_o),
        .alusel_o     (alusel_o),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .inst_valid_o (inst_valid_o),
        .reg1_o       (reg1_o),
        .reg2_o       (reg2_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_id_stage.sv
/*
 * testbench for the rv32i decode stage
 * random instructions and forwarding checked against a reference decode model
 */
`default_nettype none

module tb_id_stage;

    localparam int NUM_INSTS  = 500;
    localparam int IDLE_LIMIT = 4;

    logic                 clk;
    logic                 reset_i;
    rv32i_pkg::word_t     pc_i;
    rv32i_pkg::inst_t     inst_i;
    rv32i_pkg::word_t     reg1_data_i;
    rv32i_pkg::word_t     reg2_data_i;
    logic                 ex_wreg_i;
    rv32i_pkg::reg_addr_t ex_wd_i;
    rv32i_pkg::word_t     ex_wdata_i;
    logic                 mem_wreg_i;
    rv32i_pkg::reg_addr_t mem_wd_i;
    rv32i_pkg::word_t     mem_wdata_i;
    logic                 reg1_read_o;
    logic                 reg2_read_o;
    rv32i_pkg::reg_addr_t reg1_addr_o;
    rv32i_pkg::reg_addr_t reg2_addr_o;
    id_pkg::alu_op_e      aluop_o;
    id_pkg::alu_sel_e     alusel_o;
    rv32i_pkg::reg_addr_t wd_o;
    logic                 wreg_o;
    logic                 inst_valid_o;
    rv32i_pkg::word_t     reg1_o;
    rv32i_pkg::word_t     reg2_o;

    // expected results of the instruction now in decode
    id_pkg::alu_op_e      exp_op;
    id_pkg::alu_sel_e     exp_sel;
    rv32i_pkg::reg_addr_t exp_wd;
    logic                 exp_valid;
    logic                 exp_rd1;
    logic                 exp_rd2;
    rv32i_pkg::word_t     exp_reg1;
    rv32i_pkg::word_t     exp_reg2;

    integer seed;
    int     value_errors;
    int     timeouts;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input string exp, input string act);
        $display("[FAIL] t=%0t %s expected %s got %s", $time, name, exp, act);
        value_errors++;
    endtask

    task automatic check_word(input string name, input rv32i_pkg::word_t exp, act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_addr(input string name, input rv32i_pkg::reg_addr_t exp, act);
        if (act !== exp) report_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_op(input string name, input id_pkg::alu_op_e exp, act);
        if (act !== exp) report_mismatch(name, exp.name(), $sformatf("%0d", act));
    endtask

    task automatic check_sel(input string name, input id_pkg::alu_sel_e exp, act);
        if (act !== exp) report_mismatch(name, exp.name(), $sformatf("%0d", act));
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // execute result wins over memory result
    function automatic rv32i_pkg::word_t pick_operand(input logic rd,
                                                      input rv32i_pkg::reg_addr_t a,
                                                      input rv32i_pkg::word_t imm, rf);
        if (!rd) return imm;
        if (ex_wreg_i && ex_wd_i == a) return ex_wdata_i;
        if (mem_wreg_i && mem_wd_i == a) return mem_wdata_i;
        return rf;
    endfunction

    // reference decode written from the isa encoding tables
    task automatic model_decode(input rv32i_pkg::inst_t inst, input rv32i_pkg::word_t pc);
        logic [2:0]       f3;
        logic             shift_ok;
        rv32i_pkg::word_t imm1;
        rv32i_pkg::word_t imm2;
        f3       = inst[14:12];
        shift_ok = (f3 == 3'b001) ? (inst[31:25] == 7'h00) :
                   (f3 == 3'b101) ? (inst[31:25] == 7'h00 || inst[31:25] == 7'h20) : 1'b1;
        exp_valid = 1'b1;
        exp_rd1   = 1'b0;
        exp_rd2   = 1'b0;
        imm1      = '0;
        imm2      = '0;
        case (f3)
            3'd0: exp_op = (inst[30] && inst[6:0] == rv32i_pkg::OPC_OP) ?
                           id_pkg::OP_SUB : id_pkg::OP_ADD;
            3'd1: exp_op = id_pkg::OP_SLL;
            3'd2: exp_op = id_pkg::OP_SLT;
            3'd3: exp_op = id_pkg::OP_SLTU;
            3'd4: exp_op = id_pkg::OP_XOR;
            3'd5: exp_op = inst[30] ? id_pkg::OP_SRA : id_pkg::OP_SRL;
            3'd6: exp_op = id_pkg::OP_OR;
            3'd7: exp_op = id_pkg::OP_AND;
        endcase
        exp_sel = (f3 == 3'd0) ? id_pkg::SEL_ARITH :
                  (f3 == 3'd1 || f3 == 3'd5) ? id_pkg::SEL_SHIFT :
                  (f3 == 3'd2 || f3 == 3'd3) ? id_pkg::SEL_COMPARE : id_pkg::SEL_LOGIC;
        if (inst[6:0] == rv32i_pkg::OPC_LUI) begin
            exp_op  = id_pkg::OP_LUI;
            exp_sel = id_pkg::SEL_SHIFT;
            imm2    = {inst[31:12], 12'h000};
        end else if (inst[6:0] == rv32i_pkg::OPC_AUIPC) begin
            exp_op  = id_pkg::OP_ADD;
            exp_sel = id_pkg::SEL_ARITH;
            imm1    = pc;
            imm2    = {inst[31:12], 12'h000};
        end else if (inst[6:0] == rv32i_pkg::OPC_OP_IMM && shift_ok) begin
            exp_rd1 = 1'b1;
            imm2    = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, inst[24:20]} :
                                                   {{20{inst[31]}}, inst[31:20]};
        end else if (inst[6:0] == rv32i_pkg::OPC_OP) begin
            exp_rd1 = 1'b1;
            exp_rd2 = 1'b1;
        end else begin
            exp_op    = id_pkg::OP_NONE;
            exp_sel   = id_pkg::SEL_NONE;
            exp_valid = 1'b0;
        end
        exp_wd   = inst[11:7];
        exp_reg1 = pick_operand(exp_rd1, inst[19:15], imm1, reg1_data_i);
        exp_reg2 = pick_operand(exp_rd2, inst[24:20], imm2, reg2_data_i);
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] u;
        logic [6:0]  f7;
        logic [6:0]  opc;
        r = $random(seed);
        u = $random(seed);
        f7 = (r[21] && (r[20:18] == 3'd5 || r[2:1] == 2'b10)) ? 7'h20 : 7'h00;
        case (r[2:0])
            3'd0: inst_i = {u[31:12], r[7:3], rv32i_pkg::OPC_LUI};
            3'd1: inst_i = {u[31:12], r[7:3], rv32i_pkg::OPC_AUIPC};
            3'd2, 3'd3: begin
                if (r[20:18] == 3'd1 || r[20:18] == 3'd5)
                    inst_i = {f7, r[17:13], r[12:8], r[20:18], r[7:3], rv32i_pkg::OPC_OP_IMM};
                else
                    inst_i = {u[11:0], r[12:8], r[20:18], r[7:3], rv32i_pkg::OPC_OP_IMM};
            end
            3'd4, 3'd5: inst_i = {f7, r[17:13], r[12:8], r[20:18], r[7:3], rv32i_pkg::OPC_OP};
            3'd6: begin
                opc = u[6:0];
                if (opc == rv32i_pkg::OPC_LUI || opc == rv32i_pkg::OPC_AUIPC ||
                    opc == rv32i_pkg::OPC_OP_IMM || opc == rv32i_pkg::OPC_OP)
                    opc = 7'h7f;
                inst_i = {u[31:7], opc};
            end
            3'd7: inst_i = {u[31:25], r[17:13], r[12:8], r[20] ? 3'd1 : 3'd5, r[7:3],
                            rv32i_pkg::OPC_OP_IMM};   // mostly bad shift encodings
        endcase
        pc_i        = $random(seed);
        reg1_data_i = $random(seed);
        reg2_data_i = $random(seed);
        ex_wdata_i  = $random(seed);
        mem_wdata_i = $random(seed);
        r = $random(seed);
        ex_wreg_i  = r[0] | r[1];
        mem_wreg_i = r[2] | r[3];
        ex_wd_i  = (r[5:4] == 2'd3) ? r[20:16] : (r[5:4] == 2'd1) ? inst_i[24:20] : inst_i[19:15];
        mem_wd_i = (r[7:6] == 2'd3) ? r[25:21] : (r[7:6] == 2'd0) ? inst_i[19:15] : inst_i[24:20];
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!(wreg_o === 1'b0 && inst_valid_o === 1'b0) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(wreg_o === 1'b0 && inst_valid_o === 1'b0)) begin
            $display("timeout: outputs did not go idle within %0d cycles of reset", limit);
            timeouts++;
        end
    endtask

    initial begin
        seed = 32'h7024_fd13;
        value_errors = 0;
        timeouts = 0;
        reset_i = 1'b1;
        pc_i = '0;
        // addi x1, x2, 1 held through reset, only reset keeps it out of id/ex
        inst_i = {12'd1, 5'd2, rv32i_pkg::F3_ADD, 5'd1, rv32i_pkg::OPC_OP_IMM};
        reg1_data_i = 32'h5a5a_5a5a;
        reg2_data_i = 32'ha5a5_a5a5;
        ex_wreg_i = 1'b0;
        ex_wd_i = '0;
        ex_wdata_i = '0;
        mem_wreg_i = 1'b0;
        mem_wd_i = '0;
        mem_wdata_i = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        wait_idle(IDLE_LIMIT);
        check_op("aluop_o", id_pkg::OP_NONE, aluop_o);
        check_sel("alusel_o", id_pkg::SEL_NONE, alusel_o);
        check_addr("wd_o", '0, wd_o);
        check_word("reg1_o", '0, reg1_o);
        check_word("reg2_o", '0, reg2_o);
        for (int i = 0; i < NUM_INSTS; i++) begin
            drive_random();
            model_decode(inst_i, pc_i);
            #1;
            check_bit("reg1_read_o", exp_rd1, reg1_read_o);    // same cycle requests
            check_bit("reg2_read_o", exp_rd2, reg2_read_o);
            check_addr("reg1_addr_o", inst_i[19:15], reg1_addr_o);
            check_addr("reg2_addr_o", inst_i[24:20], reg2_addr_o);
            @(negedge clk);
            check_op("aluop_o", exp_op, aluop_o);
            check_sel("alusel_o", exp_sel, alusel_o);
            check_addr("wd_o", exp_wd, wd_o);
            check_bit("wreg_o", exp_valid, wreg_o);
            check_bit("inst_valid_o", exp_valid, inst_valid_o);
            check_word("reg1_o", exp_reg1, reg1_o);
            check_word("reg2_o", exp_reg2, reg2_o);
        end
        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/rv32i_pkg.sv
src/id_pkg.sv
src/decode_if.sv
src/inst_decoder.sv
src/operand_forward.sv
src/id_ex_reg.sv
src/id_stage.sv
verification/tb_id_stage.sv

//--- run.sh
#!/usr/bin/env bash
# builds the decode stage testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f filelist.f --top-module tb_id_stage -o sim_id_stage
./obj_dir/sim_id_stage | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
